//--- hw/mul_pkg.sv
package mul_pkg;

  localparam int data_width     = 32;              // operand and result width
  localparam int sa_width       = 5;               // shift amount width
  localparam int reg_addr_width = 5;               // destination register index width
  localparam int prod_width     = data_width + 1;  // multiplier operand with extension bit

  // Opcode encoding of the execution block.
  // Bit 2 selects the multiplier path and bit 1 marks a signed operation.
  // For shifts bit 0 marks a right shift. MTHI and MTLO sit in the spare codes
  typedef enum logic [2:0] {
    op_sll   = 3'd0,  // shift left logical
    op_srl   = 3'd1,  // shift right logical
    op_mthi  = 3'd2,  // move opa to hi
    op_sra   = 3'd3,  // shift right arithmetic
    op_multu = 3'd4,  // unsigned 32x32 multiply
    op_mtlo  = 3'd5,  // move opa to lo
    op_mult  = 3'd6   // signed 32x32 multiply
  } mul_op_e;

  // one issued command as seen by the execution block
  typedef struct packed {
    mul_op_e                   op;   // operation
    logic [reg_addr_width-1:0] dst;  // destination register, zero means discarded
    logic [data_width-1:0]     opa;  // first operand, also the shifted value
    logic [data_width-1:0]     opb;  // second operand of a multiply
    logic [sa_width-1:0]       sa;   // shift amount
  } mul_cmd_t;

  // state of the one-cycle stall machine
  typedef enum logic {
    idle = 1'b0,  // waiting for a request
    held = 1'b1   // stall cycle done, result available
  } stall_state_e;

endpackage

//--- hw/shift_decode.sv
module shift_decode
  import mul_pkg::*;
(
  input  logic [sa_width-1:0]   sa,
  input  logic                  dir,
  output logic [prod_width-1:0] decoded
);

  logic [sa_width-1:0] left_sa;  // power of two that realizes the shift

  // A left shift multiplies by 2^sa.
  // A right shift multiplies by 2^(32-sa) and the caller takes the high word.
  // 32-sa in five bits is the two's complement of sa, so sa of zero wraps to 0
  always_comb
  begin
    if (dir)
    begin
      left_sa = (~sa) + 1'b1;  // 32 - sa modulo 32
    end
    else
    begin
      left_sa = sa;
    end
  end

  // one-hot expansion of the left shift amount
  always_comb
  begin
    decoded = '0;
    for (int i = 0; i < prod_width; i++)
    begin
      if (left_sa == i)
      begin
        decoded[i] = 1'b1;  // bit 32 is never reached with a 5-bit amount
      end
    end
  end

endmodule

//--- hw/stall_ctrl.sv
module stall_ctrl
  import mul_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic request,
  output logic stalled
);

  stall_state_e state;
  stall_state_e state_next;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= idle;
    end
    else
    begin
      state <= state_next;
    end
  end

  // A request from idle costs one cycle, the cycle after it goes through.
  // A request still present after that restarts the stall for the next command
  always_comb
  begin
    state_next = state;
    stalled    = 1'b0;
    case (state)
      idle:
      begin
        if (request)
        begin
          stalled    = 1'b1;
          state_next = held;
        end
      end
      held:    state_next = idle;  // product is in the register now
      default: state_next = idle;
    endcase
  end

endmodule

//--- hw/mul_shift.sv
module mul_shift
  import mul_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  mul_cmd_t              cmd,
  output logic [data_width-1:0] prod_hi,
  output logic [data_width-1:0] prod_lo,
  output logic [data_width-1:0] shift_result
);

  logic                         is_mul;     // multiplier operands, not a shift
  logic                         is_signed;  // sign-extend the operands
  logic                         dir;        // right shift
  logic [prod_width-1:0]        decoded_sa;
  logic signed [prod_width-1:0] opa_ext;
  logic signed [prod_width-1:0] opb_ext;
  logic signed [2*prod_width-1:0] prod_q;   // full 66-bit product register

  assign is_mul    = cmd.op[2];
  assign is_signed = cmd.op[1];
  assign dir       = cmd.op[0];

  shift_decode u_shift_decode (
    .sa      (cmd.sa),
    .dir     (dir),
    .decoded (decoded_sa)
  );

  // sra carries the sign of opa into the extension bit, srl and sll do not
  assign opa_ext = {is_signed & cmd.opa[data_width-1], cmd.opa};

  // for a shift the second factor is the decoded power of two
  always_comb
  begin
    if (is_mul)
    begin
      opb_ext = {is_signed & cmd.opb[data_width-1], cmd.opb};
    end
    else
    begin
      opb_ext = decoded_sa;  // top bit stays clear so the factor is positive
    end
  end

  // One pipeline stage after the multiplier.
  // Both factors are 33-bit signed so MULTU also fits the signed array
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      prod_q <= '0;
    end
    else
    begin
      prod_q <= opa_ext * opb_ext;
    end
  end

  assign prod_hi = prod_q[2*data_width-1:data_width];
  assign prod_lo = prod_q[data_width-1:0];

  // A right shift lands in the high word except for sa of zero, which
  // multiplies by one and so leaves the operand in the low word
  always_comb
  begin
    if (dir && (|cmd.sa))
    begin
      shift_result = prod_hi;
    end
    else
    begin
      shift_result = prod_lo;
    end
  end

endmodule

//--- hw/hilo_regs.sv
module hilo_regs
  import mul_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load_prod,
  input  logic                  write_hi,
  input  logic                  write_lo,
  input  logic [data_width-1:0] prod_hi,
  input  logic [data_width-1:0] prod_lo,
  input  logic [data_width-1:0] wdata,
  output logic [data_width-1:0] hi,
  output logic [data_width-1:0] lo
);

  // HI holds the upper product word or an MTHI value
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi <= '0;
    end
    else if (load_prod)
    begin
      hi <= prod_hi;  // multiply completing this cycle
    end
    else if (write_hi)
    begin
      hi <= wdata;
    end
  end

  // LO holds the lower product word or an MTLO value
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      lo <= '0;
    end
    else if (load_prod)
    begin
      lo <= prod_lo;
    end
    else if (write_lo)
    begin
      lo <= wdata;
    end
  end

endmodule

//--- hw/mul_unit.sv
module mul_unit
  import mul_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  mul_cmd_t              cmd,
  output logic                  stalled,
  output logic [data_width-1:0] shift_result,
  output logic [data_width-1:0] hi,
  output logic [data_width-1:0] lo
);

  logic                  is_mul;     // mult or multu
  logic                  is_shift;   // sll, srl or sra
  logic                  request;    // command needs the registered product
  logic                  load_prod;  // multiply result goes to hi and lo
  logic                  write_hi;
  logic                  write_lo;
  logic [data_width-1:0] prod_hi;
  logic [data_width-1:0] prod_lo;

  assign is_mul   = (cmd.op == op_mult) || (cmd.op == op_multu);
  assign is_shift = (cmd.op == op_sll) || (cmd.op == op_srl) || (cmd.op == op_sra);

  // a shift into register zero has no consumer, so it need not wait
  assign request = start & (is_mul | (is_shift & (|cmd.dst)));

  // stalled is low in the second cycle of a multiply, the product is ready then
  assign load_prod = start & is_mul & ~stalled;
  assign write_hi  = start & (cmd.op == op_mthi);
  assign write_lo  = start & (cmd.op == op_mtlo);

  mul_shift u_mul_shift (
    .clk          (clk),
    .reset        (reset),
    .cmd          (cmd),
    .prod_hi      (prod_hi),
    .prod_lo      (prod_lo),
    .shift_result (shift_result)
  );

  stall_ctrl u_stall_ctrl (
    .clk     (clk),
    .reset   (reset),
    .request (request),
    .stalled (stalled)
  );

  hilo_regs u_hilo_regs (
    .clk       (clk),
    .reset     (reset),
    .load_prod (load_prod),
    .write_hi  (write_hi),
    .write_lo  (write_lo),
    .prod_hi   (prod_hi),
    .prod_lo   (prod_lo),
    .wdata     (cmd.opa),  // mthi and mtlo move the first operand
    .hi        (hi),
    .lo        (lo)
  );

endmodule

//--- sim/mul_unit_assert.sv
module mul_unit_assert
  import mul_pkg::*;
(
  input logic                  clk,
  input logic                  reset,
  input logic                  stalled,
  input logic                  load_prod,
  input logic [data_width-1:0] hi,
  input logic [data_width-1:0] lo
);

  timeunit 1ns;
  timeprecision 1ps;

  // the product is registered after one cycle, so a stall never repeats directly
  no_double_stall: assert property (@(posedge clk) disable iff (reset) stalled |=> !stalled)
    else $error("stalled stayed high for two cycles");

  no_stall_in_reset: assert property (@(posedge clk) reset |-> !stalled)
    else $error("stalled high while reset is asserted");

  no_stall_after_reset: assert property (@(posedge clk) $fell(reset) |-> !stalled)
    else $error("stalled high in the first cycle after reset");

  hilo_cleared: assert property (@(posedge clk) reset |=> (hi == '0) && (lo == '0))
    else $error("hi or lo not zero after reset");

  // hi and lo take the product only in the cycle right after the stall
  load_after_stall: assert property (@(posedge clk) disable iff (reset)
                                     load_prod |-> $past(stalled))
    else $error("product load without a preceding stall cycle");

endmodule

bind mul_unit mul_unit_assert u_mul_unit_assert (
  .clk       (clk),
  .reset     (reset),
  .stalled   (stalled),
  .load_prod (load_prod),
  .hi        (hi),
  .lo        (lo)
);

//--- sim/mul_unit_tb.sv
module mul_unit_tb
  import mul_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int stall_limit = 16;  // cycles a stall may last before the run gives up

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  start;
  mul_cmd_t              cmd;
  logic                  stalled;
  logic [data_width-1:0] shift_result;
  logic [data_width-1:0] hi;
  logic [data_width-1:0] lo;

  logic [31:0] lcg_state;
  logic [31:0] model_hi;  // hi as the writes issued so far define it
  logic [31:0] model_lo;  // lo as the writes issued so far define it
  int          errors;
  int          tests;
  bit          aborted;  // a wait ran out of time, remaining tests are skipped

  always #4 clk = ~clk;  // 8 ns period

  mul_unit dut0 (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .cmd          (cmd),
    .stalled      (stalled),
    .shift_result (shift_result),
    .hi           (hi),
    .lo           (lo)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    errors++;
    $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic report_problem(string what);
    errors++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic finish_test(string name, int first_errors);
    tests++;
    $display("test %s finished with %0d errors", name, errors - first_errors);
  endtask

  // the command goes out on a falling edge and stays until the caller releases start
  task automatic issue(mul_op_e op, logic [4:0] dst, logic [31:0] opa, logic [31:0] opb,
                       logic [4:0] sa);
    @(negedge clk);
    cmd.op  = op;
    cmd.dst = dst;
    cmd.opa = opa;
    cmd.opb = opb;
    cmd.sa  = sa;
    start   = 1'b1;
  endtask

  // returns on the first falling edge where stalled is low, counting the stall cycles
  task automatic wait_stall_end(output int cycles);
    int waited;
    cycles = 0;
    waited = 0;
    #1;  // stalled follows start combinationally
    if (stalled)
    begin
      cycles = 1;
    end
    @(negedge clk);
    while (stalled && !aborted)
    begin
      cycles++;
      waited++;
      if (waited > stall_limit)
      begin
        aborted = 1'b1;
        report_problem("stalled stayed high and never fell");
      end
      else
      begin
        @(negedge clk);
      end
    end
  endtask

  task automatic run_shift(mul_op_e op, logic [4:0] dst, logic [31:0] opa, logic [4:0] sa);
    logic [31:0] expected;
    int          cycles;
    int          expected_cycles;
    if (aborted)
    begin
      return;
    end
    case (op)
      op_sll:  expected = opa << sa;
      op_srl:  expected = opa >> sa;
      default: expected = $signed(opa) >>> sa;  // sra copies the sign bit
    endcase
    expected_cycles = (dst != 5'd0) ? 1 : 0;
    issue(op, dst, opa, 32'h0, sa);
    wait_stall_end(cycles);
    if (aborted)
    begin
      return;
    end
    if (cycles != expected_cycles)
    begin
      report_mismatch("stall cycles", expected_cycles, cycles);
    end
    if (shift_result !== expected)
    begin
      report_mismatch("shift_result", expected, shift_result);
    end
    if (expected_cycles != 0)
    begin
      @(negedge clk);  // a stalled command stays through its completion edge
    end
    start = 1'b0;
  endtask

  task automatic run_mult(mul_op_e op, logic [31:0] a, logic [31:0] b);
    logic [63:0] expected;
    int          cycles;
    if (aborted)
    begin
      return;
    end
    if (op == op_mult)
    begin
      expected = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    end
    else
    begin
      expected = {32'h0, a} * {32'h0, b};
    end
    issue(op, 5'd0, a, b, 5'd0);
    wait_stall_end(cycles);
    if (aborted)
    begin
      return;
    end
    if (cycles != 1)
    begin
      report_mismatch("stall cycles", 1, cycles);
    end
    @(negedge clk);  // hi and lo load on the edge that ends the second cycle
    if (hi !== expected[63:32])
    begin
      report_mismatch("hi", expected[63:32], hi);
    end
    if (lo !== expected[31:0])
    begin
      report_mismatch("lo", expected[31:0], lo);
    end
    model_hi = expected[63:32];
    model_lo = expected[31:0];
    start    = 1'b0;
  endtask

  task automatic run_move(mul_op_e op, logic [31:0] value);
    logic [31:0] expected_hi;
    logic [31:0] expected_lo;
    int          cycles;
    if (aborted)
    begin
      return;
    end
    expected_hi = (op == op_mthi) ? value : model_hi;
    expected_lo = (op == op_mtlo) ? value : model_lo;
    issue(op, 5'd0, value, next_rand(), 5'd0);
    wait_stall_end(cycles);
    if (cycles != 0)
    begin
      report_mismatch("stall cycles", 0, cycles);
    end
    if (hi !== expected_hi)
    begin
      report_mismatch("hi", expected_hi, hi);
    end
    if (lo !== expected_lo)
    begin
      report_mismatch("lo", expected_lo, lo);
    end
    model_hi = expected_hi;
    model_lo = expected_lo;
    start    = 1'b0;
  endtask

  task automatic test_reset();
    int first;
    first = errors;
    @(negedge clk);
    if (stalled !== 1'b0)
    begin
      report_mismatch("stalled", 0, stalled);
    end
    if (hi !== '0)
    begin
      report_mismatch("hi", 0, hi);
    end
    if (lo !== '0)
    begin
      report_mismatch("lo", 0, lo);
    end
    finish_test("reset", first);
  endtask

  task automatic test_shifts();
    mul_op_e ops [3] = '{op_sll, op_srl, op_sra};
    int      first;
    first = errors;
    foreach (ops[i])
    begin
      for (int sa = 0; sa < 32; sa++)
      begin
        run_shift(ops[i], 5'(next_rand() % 31 + 1), next_rand(), 5'(sa));
      end
    end
    finish_test("shifts", first);
  endtask

  task automatic test_multiplies();
    logic [31:0] corner [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    int          first;
    first = errors;
    foreach (corner[i])
    begin
      foreach (corner[j])
      begin
        run_mult(op_mult, corner[i], corner[j]);
        run_mult(op_multu, corner[i], corner[j]);
      end
    end
    for (int n = 0; n < 20; n++)
    begin
      run_mult(op_mult, next_rand(), next_rand());
      run_mult(op_multu, next_rand(), next_rand());
    end
    finish_test("multiplies", first);
  endtask

  task automatic test_zero_dst();
    int first;
    first = errors;
    for (int n = 0; n < 12; n++)
    begin
      run_shift(op_sll, 5'd0, next_rand(), 5'(next_rand()));
      run_shift(op_srl, 5'd0, next_rand(), 5'(next_rand()));
      run_shift(op_sra, 5'd0, next_rand(), 5'(next_rand()));
    end
    finish_test("zero destination", first);
  endtask

  task automatic test_hilo_writes();
    int first;
    first = errors;
    run_move(op_mthi, next_rand());
    run_move(op_mtlo, next_rand());
    run_move(op_mtlo, next_rand());
    run_move(op_mthi, next_rand());
    run_mult(op_mult, next_rand(), next_rand());  // the product replaces both moved values
    run_move(op_mtlo, 32'hdead_beef);
    run_mult(op_multu, next_rand(), next_rand());
    finish_test("hi lo writes", first);
  endtask

  initial
  begin
    lcg_state = 32'hcbdd;
    model_hi  = '0;
    model_lo  = '0;
    errors    = 0;
    tests     = 0;
    aborted   = 1'b0;
    reset     = 1'b1;
    start     = 1'b0;
    cmd       = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    test_reset();
    test_shifts();
    test_multiplies();
    test_zero_dst();
    test_hilo_writes();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0 && !aborted)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
hw/mul_pkg.sv
hw/shift_decode.sv
hw/stall_ctrl.sv
hw/mul_shift.sv
hw/hilo_regs.sv
hw/mul_unit.sv
sim/mul_unit_assert.sv
sim/mul_unit_tb.sv
